// ==== all.f ====
+incdir+verification
hw/icache_pkg.sv
hw/icache.sv
hw/bus_arbiter.sv
hw/wait_state_ram.sv
hw/icache_sys.sv
verification/icache_sys_tb.sv

// ==== verification/icache_tb_model.svh ====
`ifndef ICACHE_TB_MODEL_SVH
`define ICACHE_TB_MODEL_SVH

localparam logic [31:0] lfsr_seed = 32'd66137;

// shadow copy of the RAM, updated on every data-port write
word_t shadow_mem [ram_words];
logic [31:0] lfsr_state = lfsr_seed;

// word index wraps modulo 4 KiB like the RAM
function automatic logic [ram_words_log2-1:0] shadow_index(addr_t a);
	return a[byte_sel_w +: ram_words_log2];
endfunction

function automatic word_t expected_word(addr_t a);
	return shadow_mem[shadow_index(a)];
endfunction

function automatic void shadow_write(addr_t a, word_t w);
	shadow_mem[shadow_index(a)] = w;
endfunction

// fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
	logic fb;
	fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], fb};
	return fb;
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] random_bits(int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++)
		r = {r[30:0], lfsr_bit()};
	return r;
endfunction

`endif

// ==== verification/icache_sys_tb.sv ====
`timescale 1ns/10ps

module icache_sys_tb;
	import icache_pkg::*;

	localparam int line_bytes = words_per_line * 4;
	// run length: data-port accesses, line fills and hit fetches
	localparam int dp_accesses = 372;
	localparam int line_fills = 21;
	localparam int hit_fetches = 40;
	localparam int beat_budget = 2 * dp_accesses + line_fills * (words_per_line + 2)
		+ 2 * hit_fetches;
	localparam int watchdog_cycles = beat_budget * (wait_states + 2) + 500;

	logic clk;
	logic rst;
	logic flush;
	logic rd_req;
	addr_t rd_addr;
	logic rd_wait;
	word_t rd_data;
	logic dp_req;
	logic dp_wr;
	addr_t dp_addr;
	word_t dp_wdata;
	logic dp_ready;
	word_t dp_rdata;
	int value_errors = 0;
	int protocol_errors = 0;

	`include "icache_tb_model.svh"

	icache_sys icache_sys_i (
		.clk      (clk),
		.rst      (rst),
		.flush    (flush),
		.rd_req   (rd_req),
		.rd_addr  (rd_addr),
		.rd_wait  (rd_wait),
		.rd_data  (rd_data),
		.dp_req   (dp_req),
		.dp_wr    (dp_wr),
		.dp_addr  (dp_addr),
		.dp_wdata (dp_wdata),
		.dp_ready (dp_ready),
		.dp_rdata (dp_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("run timed out after %0d cycles", watchdog_cycles);
		$display("tests failed");
		$finish;
	end

	// port rules, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst) begin
			assert (rd_req || !rd_wait) else begin
				protocol_errors++;
				$display("rd_wait is high while no fetch is requested");
			end
			assert (dp_req || !dp_ready) else begin
				protocol_errors++;
				$display("dp_ready pulsed without a data-port request");
			end
		end
	end

	task automatic check_word(string name, word_t exp, word_t got);
		assert (got === exp) else begin
			value_errors++;
			$display("error %s expected %h got %h", name, exp, got);
		end
	endtask

	task automatic check_wait(addr_t a, logic exp, logic got);
		assert (got === exp) else begin
			value_errors++;
			$display("error rd_wait at address %h expected %h got %h", a, exp, got);
		end
	endtask

	// one access, held until dp_ready
	task automatic dp_access(logic wr, addr_t a, word_t w, output word_t r);
		@(posedge clk);
		dp_req <= 1'b1;
		dp_wr <= wr;
		dp_addr <= a;
		dp_wdata <= w;
		do
			@(negedge clk);
		while (!dp_ready);
		r = dp_rdata;
		@(posedge clk);
		dp_req <= 1'b0;
		dp_wr <= 1'b0;
	endtask

	task automatic write_word(addr_t a, word_t w);
		word_t unused;
		dp_access(1'b1, a, w, unused);
		shadow_write(a, w);
	endtask

	task automatic load_line(addr_t base);
		for (int i = 0; i < words_per_line; i++)
			write_word(base + addr_t'(4 * i), random_bits(data_w));
	endtask

	// hold the request while rd_wait, data comes a cycle after acceptance
	task automatic fetch(addr_t a, output word_t r, output logic waited);
		@(posedge clk);
		rd_req <= 1'b1;
		rd_addr <= a;
		waited = 1'b0;
		@(negedge clk);
		while (rd_wait) begin
			waited = 1'b1;
			@(negedge clk);
		end
		@(posedge clk);
		rd_req <= 1'b0;
		@(negedge clk);
		r = rd_data;
	endtask

	task automatic fetch_and_check(addr_t a, logic exp_wait);
		word_t got;
		logic waited;
		fetch(a, got, waited);
		check_wait(a, exp_wait, waited);
		check_word("rd_data", expected_word(a), got);
	endtask

	// a new address every cycle, all expected to hit
	task automatic fetch_burst(addr_t base);
		@(posedge clk);
		rd_req <= 1'b1;
		for (int i = 0; i < words_per_line; i++) begin
			rd_addr <= base + addr_t'(4 * i);
			@(negedge clk);
			check_wait(base + addr_t'(4 * i), 1'b0, rd_wait);
			if (i > 0)
				check_word("rd_data", expected_word(base + addr_t'(4 * (i - 1))), rd_data);
			@(posedge clk);
		end
		rd_req <= 1'b0;
		@(negedge clk);
		check_word("rd_data", expected_word(base + addr_t'(line_bytes - 4)), rd_data);
	endtask

	initial begin
		word_t got;
		word_t old_word;
		word_t new_word;
		logic waited;
		addr_t a;
		addr_t b;
		rst = 1'b1;
		flush = 1'b0;
		rd_req = 1'b0;
		rd_addr = '0;
		dp_req = 1'b0;
		dp_wr = 1'b0;
		dp_addr = '0;
		dp_wdata = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// program load, first four lines read back through the data port
		for (int l = 0; l < num_lines; l++)
			load_line(addr_t'(l * line_bytes));
		for (int i = 0; i < 64; i++) begin
			dp_access(1'b0, addr_t'(4 * i), '0, got);
			check_word("dp_rdata", expected_word(addr_t'(4 * i)), got);
		end

		// cache still cold after reset
		for (int l = 0; l < num_lines; l++)
			fetch_and_check(addr_t'(l * line_bytes) + (random_bits(word_sel_w) << 2), 1'b1);

		// miss then hits in the same line
		a = 32'h400 + 5 * line_bytes;
		load_line(a);
		fetch_and_check(a + 12, 1'b1);
		fetch_burst(a);

		// same index, different tag
		a = 7 * line_bytes + 8;
		b = 32'h800 + 7 * line_bytes + 8;
		load_line(b - 8);
		fetch_and_check(a, 1'b0);
		fetch_and_check(b, 1'b1);
		fetch_and_check(a, 1'b1);

		// no coherence, old word stays cached until flush
		a = 9 * line_bytes + 20;
		fetch_and_check(a, 1'b0);
		old_word = expected_word(a);
		new_word = random_bits(data_w);
		write_word(a, new_word);
		fetch(a, got, waited);
		check_wait(a, 1'b0, waited);
		check_word("rd_data", old_word, got);
		@(posedge clk);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		fetch_and_check(a, 1'b1);

		// data-port traffic while a fill owns the bus
		a = 32'hc00 + 2 * line_bytes;
		b = 32'h400 + 12 * line_bytes;
		load_line(a);
		new_word = random_bits(data_w);
		fork
			fetch_and_check(a + 12, 1'b1);
			begin
				repeat (3) @(posedge clk);
				write_word(b, new_word);
				dp_access(1'b0, b, '0, got);
				check_word("dp_rdata", expected_word(b), got);
			end
		join
		fetch_burst(a);

		repeat (2) @(posedge clk);
		$display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== hw/icache_sys.sv ====
`timescale 1ns/10ps

module icache_sys (
	input  logic              clk,
	input  logic              rst,
	input  logic              flush,
	// instruction fetch port
	input  logic              rd_req,
	input  icache_pkg::addr_t rd_addr,
	output logic              rd_wait,
	output icache_pkg::word_t rd_data,
	// uncached data port
	input  logic              dp_req,
	input  logic              dp_wr,
	input  icache_pkg::addr_t dp_addr,
	input  icache_pkg::word_t dp_wdata,
	output logic              dp_ready,
	output icache_pkg::word_t dp_rdata
);
	import icache_pkg::*;

	// cache as bus master
	logic ic_req;
	logic ic_ack;
	logic ic_ready;
	logic ic_rd;
	addr_t ic_addr;

	// arbiter to RAM
	logic ram_rd;
	logic ram_wr;
	addr_t ram_addr;
	word_t ram_wdata;
	word_t ram_rdata;
	logic ram_ready;

	assign dp_rdata = ram_rdata;	// read data fans out to both masters

	icache icache_i (
		.clk       (clk),
		.rst       (rst),
		.flush     (flush),
		.rd_req    (rd_req),
		.rd_addr   (rd_addr),
		.rd_wait   (rd_wait),
		.rd_data   (rd_data),
		.bus_req   (ic_req),
		.bus_ack   (ic_ack),
		.bus_ready (ic_ready),
		.bus_rd    (ic_rd),
		.bus_addr  (ic_addr),
		.bus_rdata (ram_rdata)
	);

	bus_arbiter bus_arbiter_i (
		.clk       (clk),
		.rst       (rst),
		.dp_req    (dp_req),
		.dp_wr     (dp_wr),
		.dp_addr   (dp_addr),
		.dp_wdata  (dp_wdata),
		.dp_ack    (),	// outside only sees dp_ready
		.dp_ready  (dp_ready),
		.ic_req    (ic_req),
		.ic_rd     (ic_rd),
		.ic_addr   (ic_addr),
		.ic_ack    (ic_ack),
		.ic_ready  (ic_ready),
		.ram_rd    (ram_rd),
		.ram_wr    (ram_wr),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_ready (ram_ready)
	);

	wait_state_ram wait_state_ram_i (
		.clk   (clk),
		.rst   (rst),
		.rd    (ram_rd),
		.wr    (ram_wr),
		.addr  (ram_addr),
		.wdata (ram_wdata),
		.rdata (ram_rdata),
		.ready (ram_ready)
	);

endmodule

// ==== hw/wait_state_ram.sv ====
`timescale 1ns/10ps

module wait_state_ram (
	input  logic              clk,
	input  logic              rst,
	input  logic              rd,
	input  logic              wr,
	input  icache_pkg::addr_t addr,
	input  icache_pkg::word_t wdata,
	output icache_pkg::word_t rdata,
	output logic              ready
);
	import icache_pkg::*;

	// zero wait states still costs one registered cycle
	localparam int wait_cnt_w = $clog2(wait_states + 2);
	localparam int last_wait = (wait_states > 0) ? wait_states - 1 : 0;

	word_t mem [ram_words];
	logic [ram_words_log2-1:0] word_addr;
	logic [wait_cnt_w-1:0] wait_cnt;
	logic beat;
	logic beat_end;

	assign word_addr = addr[byte_sel_w +: ram_words_log2];	// upper bits wrap
	assign beat = rd || wr;
	assign beat_end = beat && !ready && (wait_cnt == wait_cnt_w'(last_wait));

	always_ff @(posedge clk) begin
		if (rst) begin
			ready <= 1'b0;
			wait_cnt <= '0;
		end else if (ready || !beat) begin
			ready <= 1'b0;	// one cycle pulse, a held strobe starts over
			wait_cnt <= '0;
		end else if (beat_end) begin
			ready <= 1'b1;
		end else begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	// access happens on the edge that raises ready
	always_ff @(posedge clk) begin
		if (beat_end) begin
			if (wr)
				mem[word_addr] <= wdata;
			rdata <= mem[word_addr];
		end
	end

endmodule

// ==== hw/bus_arbiter.sv ====
`timescale 1ns/10ps

module bus_arbiter (
	input  logic              clk,
	input  logic              rst,
	// data port master
	input  logic              dp_req,
	input  logic              dp_wr,
	input  icache_pkg::addr_t dp_addr,
	input  icache_pkg::word_t dp_wdata,
	output logic              dp_ack,
	output logic              dp_ready,
	// cache master, read only
	input  logic              ic_req,
	input  logic              ic_rd,
	input  icache_pkg::addr_t ic_addr,
	output logic              ic_ack,
	output logic              ic_ready,
	// RAM slave
	output logic              ram_rd,
	output logic              ram_wr,
	output icache_pkg::addr_t ram_addr,
	output icache_pkg::word_t ram_wdata,
	input  logic              ram_ready
);
	import icache_pkg::*;

	bus_owner_t owner;
	bus_owner_t owner_next;

	// fixed priority, data port first; an owner keeps the bus while it requests
	always_comb begin
		owner_next = owner;
		case (owner)
			owner_data: begin
				if (!dp_req)
					owner_next = ic_req ? owner_cache : owner_none;
			end
			owner_cache: begin
				if (!ic_req)
					owner_next = dp_req ? owner_data : owner_none;
			end
			default: begin
				if (dp_req)
					owner_next = owner_data;
				else if (ic_req)
					owner_next = owner_cache;
				else
					owner_next = owner_none;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			owner <= owner_none;
		else
			owner <= owner_next;
	end

	assign dp_ack = (owner == owner_data);
	assign ic_ack = (owner == owner_cache);

	// ready only reaches the granted master
	assign dp_ready = dp_ack && ram_ready;
	assign ic_ready = ic_ack && ram_ready;

	// only the data port ever writes
	assign ram_wdata = dp_wdata;
	assign ram_addr = ic_ack ? ic_addr : dp_addr;
	assign ram_rd = (dp_ack && dp_req && !dp_wr) || (ic_ack && ic_rd);
	assign ram_wr = dp_ack && dp_req && dp_wr;

endmodule

// ==== hw/icache.sv ====
`timescale 1ns/10ps

module icache (
	input  logic              clk,
	input  logic              rst,
	input  logic              flush,
	input  logic              rd_req,
	input  icache_pkg::addr_t rd_addr,
	output logic              rd_wait,
	output icache_pkg::word_t rd_data,
	output logic              bus_req,
	input  logic              bus_ack,
	input  logic              bus_ready,
	output logic              bus_rd,
	output icache_pkg::addr_t bus_addr,
	input  icache_pkg::word_t bus_rdata
);
	import icache_pkg::*;

	localparam word_idx_t last_pos = word_idx_t'(words_per_line - 1);

	logic [num_lines-1:0] valid;
	tag_t tags [num_lines];
	word_t data_mem [num_lines * words_per_line];	// indexed by {line, word}

	// request fields
	tag_t req_tag;
	line_idx_t req_line;
	word_idx_t req_word;
	logic hit;

	// fill sequencer
	fill_state_t state;
	tag_t fill_tag;
	line_idx_t fill_line;
	word_idx_t fill_pos;
	logic beat_done;
	logic fill_stale;
	logic fill_last;

	assign req_tag = rd_addr[addr_w-1 -: tag_w];
	assign req_line = rd_addr[byte_sel_w + word_sel_w +: index_w];
	assign req_word = rd_addr[byte_sel_w +: word_sel_w];

	assign hit = valid[req_line] && (tags[req_line] == req_tag);
	assign rd_wait = rd_req && !hit;

	// bus side is driven from the captured miss address, not the live one
	assign bus_req = (state == fill_busy);
	assign bus_rd = (state == fill_busy) && bus_ack;
	assign bus_addr = {fill_tag, fill_line, fill_pos, {byte_sel_w{1'b0}}};

	assign beat_done = bus_rd && bus_ready;
	assign fill_last = (fill_pos == last_pos);

	// core gave up on the line or moved to another one
	assign fill_stale = !rd_req || (req_tag != fill_tag) || (req_line != fill_line);

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			state <= fill_idle;
			valid <= '0;	// every line invalid, an open fill is dropped too
			fill_pos <= '0;
		end else begin
			case (state)
				fill_idle: begin
					if (rd_wait) begin
						state <= fill_busy;
						valid[req_line] <= 1'b0;	// line is rewritten from here on
						fill_pos <= '0;
					end
				end
				fill_busy: begin
					if (fill_stale) begin
						state <= fill_idle;	// abandon, line stays invalid
					end else if (beat_done) begin
						fill_pos <= fill_pos + 1'b1;
						if (fill_last) begin
							valid[fill_line] <= 1'b1;
							state <= fill_idle;
						end
					end
				end
				default: state <= fill_idle;
			endcase
		end
	end

	// capture the missing line when the fill starts
	always_ff @(posedge clk) begin
		if (state == fill_idle && rd_wait) begin
			fill_tag <= req_tag;
			fill_line <= req_line;
		end
	end

	// tag goes in with the last word of the line
	always_ff @(posedge clk) begin
		if (beat_done && fill_last && !fill_stale)
			tags[fill_line] <= fill_tag;
	end

	always_ff @(posedge clk) begin
		if (beat_done)
			data_mem[{fill_line, fill_pos}] <= bus_rdata;
	end

	// read register, data one cycle after acceptance
	always_ff @(posedge clk) begin
		rd_data <= data_mem[{req_line, req_word}];
	end

endmodule

// ==== hw/icache_pkg.sv ====
package icache_pkg;

	// address and data widths
	localparam int addr_w = 32;
	localparam int data_w = 32;

	// address split: [31 tag 10] [9 line 6] [5 word 2] [1 byte 0]
	localparam int tag_w = 22;
	localparam int index_w = 4;
	localparam int word_sel_w = 4;
	localparam int byte_sel_w = 2;

	// cache geometry
	localparam int num_lines = 16;
	localparam int words_per_line = 16;

	// backing RAM, 1024 words, wraps modulo 4 KiB
	localparam int ram_words_log2 = 10;
	localparam int ram_words = 1 << ram_words_log2;
	localparam int wait_states = 1;	// idle cycles before each bus_ready

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [data_w-1:0] word_t;
	typedef logic [tag_w-1:0] tag_t;
	typedef logic [index_w-1:0] line_idx_t;
	typedef logic [word_sel_w-1:0] word_idx_t;

	// line fill sequencer
	typedef enum logic {
		fill_idle,
		fill_busy
	} fill_state_t;

	// who holds the shared bus
	typedef enum logic [1:0] {
		owner_none,
		owner_data,
		owner_cache
	} bus_owner_t;

endpackage
